// File: files.f
+incdir+.
nano_mu_pkg.sv
nano_mu.sv
nano_dmmu.sv
nano_dram.sv
nano_lsu_top.sv
nano_lsu_sva.sv
tb_nano_lsu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the testbench with Verilator, result taken from the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module tb_nano_lsu -f files.f -o sim_tb

# The simulator exits non-zero on a failed check, the log decides
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "sim passed" sim.log; then
   echo "Simulation OK"
   exit 0
else
   echo "Simulation FAILED"
   exit 1
fi

// File: tb_nano_lsu.sv
// ==================================================
// Table-driven testbench that writes RAM words before reading them
// Low region words are compared with an earlier load
// ==================================================
`timescale 1ns/10ps

module tb_nano_lsu;

   localparam int RST_CYCLES = 4;
   localparam int N_ENTRIES  = 26;
   // Operation codes of the table
   localparam logic [1:0] OP_NONE = 2'd0;
   localparam logic [1:0] OP_LD   = 2'd1;
   localparam logic [1:0] OP_ST   = 2'd2;
   // Size codes of byte, halfword and word
   localparam nano_mu_pkg::size_t SZ_B = 3'd1;
   localparam nano_mu_pkg::size_t SZ_H = 3'd2;
   localparam nano_mu_pkg::size_t SZ_W = 3'd3;
   // Load data checks
   localparam logic [1:0] CHK_NONE = 2'd0;
   localparam logic [1:0] CHK_DATA = 2'd1;
   localparam logic [1:0] CHK_SAVE = 2'd2;
   localparam logic [1:0] CHK_SAME = 2'd3;
   // Expected targets are the vector divided by 4
   // Zero stands for no exception
   localparam nano_mu_pkg::exp_tgt_t TGT_NONE  = 30'h0;
   localparam nano_mu_pkg::exp_tgt_t TGT_DTM   = 30'h7;
   localparam nano_mu_pkg::exp_tgt_t TGT_DPF   = 30'h8;
   localparam nano_mu_pkg::exp_tgt_t TGT_ALIGN = 30'h9;

   typedef struct packed {
      logic [1:0]            op;
      nano_mu_pkg::size_t    size;
      logic                  sign;
      nano_mu_pkg::data_t    op1;
      nano_mu_pkg::data_t    op2;
      nano_mu_pkg::data_t    op3;
      logic [1:0]            chk;
      nano_mu_pkg::data_t    data;
      nano_mu_pkg::exp_tgt_t tgt;
   } entry_t;

   logic                  clk;
   logic                  rst_n;
   logic                  in_valid;
   logic                  in_ready;
   logic                  load;
   logic                  store;
   logic                  sign_ext;
   nano_mu_pkg::size_t    load_size;
   nano_mu_pkg::size_t    store_size;
   nano_mu_pkg::data_t    operand_1;
   nano_mu_pkg::data_t    operand_2;
   nano_mu_pkg::data_t    operand_3;
   logic                  wb_ready;
   logic                  wb_valid;
   nano_mu_pkg::data_t    load_data;
   logic                  exp_taken;
   nano_mu_pkg::exp_tgt_t exp_tgt;
   nano_mu_pkg::addr_t    lsa;

   entry_t             stim [N_ENTRIES];
   int                 n_fill;
   nano_mu_pkg::data_t saved_word;

   nano_lsu_top uut (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_valid   (in_valid),
      .in_ready   (in_ready),
      .load       (load),
      .store      (store),
      .sign_ext   (sign_ext),
      .load_size  (load_size),
      .store_size (store_size),
      .operand_1  (operand_1),
      .operand_2  (operand_2),
      .operand_3  (operand_3),
      .wb_ready   (wb_ready),
      .wb_valid   (wb_valid),
      .load_data  (load_data),
      .exp_taken  (exp_taken),
      .exp_tgt    (exp_tgt),
      .lsa        (lsa)
   );

   // 20 ns clock
   always #10 clk = ~clk;

   task automatic abort_run();
      $display("sim failed");
      $fatal(1);
   endtask

   // 40 cycles per entry plus reset
   initial begin
      #((RST_CYCLES + 40 * N_ENTRIES) * 20);
      $display("Timeout: a request did not complete in the allowed time");
      abort_run();
   end

   task automatic add_entry(input logic [1:0] op, input nano_mu_pkg::size_t size,
                            input logic sign, input nano_mu_pkg::data_t op1,
                            input nano_mu_pkg::data_t op2, input nano_mu_pkg::data_t op3,
                            input logic [1:0] chk, input nano_mu_pkg::data_t data,
                            input nano_mu_pkg::exp_tgt_t tgt);
      stim[n_fill] = {op, size, sign, op1, op2, op3, chk, data, tgt};
      n_fill++;
   endtask

   task automatic fill_table();
      n_fill = 0;
      // Word store and load back through different operand splits
      add_entry(OP_ST, SZ_W, 1'b0, 32'h100, 32'h20, 32'hDEADBEEF, CHK_NONE, 32'h0, TGT_NONE);
      add_entry(OP_LD, SZ_W, 1'b0, 32'h110, 32'h10, 32'h0, CHK_DATA, 32'hDEADBEEF, TGT_NONE);
      // Byte and halfword merged into a known word
      add_entry(OP_ST, SZ_W, 1'b0, 32'h200, 32'h0, 32'h11223344, CHK_NONE, 32'h0, TGT_NONE);
      add_entry(OP_ST, SZ_B, 1'b0, 32'h200, 32'h1, 32'h000000AA, CHK_NONE, 32'h0, TGT_NONE);
      add_entry(OP_ST, SZ_H, 1'b0, 32'h200, 32'h2, 32'h0000BEEF, CHK_NONE, 32'h0, TGT_NONE);
      add_entry(OP_LD, SZ_W, 1'b0, 32'h200, 32'h0, 32'h0, CHK_DATA, 32'hBEEFAA44, TGT_NONE);
      // Sign and zero extension
      add_entry(OP_ST, SZ_W, 1'b0, 32'h300, 32'h0, 32'hC3A59681, CHK_NONE, 32'h0, TGT_NONE);
      add_entry(OP_LD, SZ_B, 1'b1, 32'h300, 32'h0, 32'h0, CHK_DATA, 32'hFFFFFF81, TGT_NONE);
      add_entry(OP_LD, SZ_B, 1'b0, 32'h300, 32'h3, 32'h0, CHK_DATA, 32'h000000C3, TGT_NONE);
      add_entry(OP_LD, SZ_H, 1'b1, 32'h300, 32'h2, 32'h0, CHK_DATA, 32'hFFFFC3A5, TGT_NONE);
      add_entry(OP_LD, SZ_H, 1'b0, 32'h300, 32'h0, 32'h0, CHK_DATA, 32'h00009681, TGT_NONE);
      add_entry(OP_LD, SZ_B, 1'b1, 32'h2FF, 32'h2, 32'h0, CHK_DATA, 32'hFFFFFF96, TGT_NONE);
      // Misaligned accesses leave memory as it was
      add_entry(OP_ST, SZ_W, 1'b0, 32'h300, 32'h2, 32'h12345678, CHK_NONE, 32'h0, TGT_ALIGN);
      add_entry(OP_ST, SZ_H, 1'b0, 32'h300, 32'h1, 32'h0000FFFF, CHK_NONE, 32'h0, TGT_ALIGN);
      add_entry(OP_LD, SZ_W, 1'b0, 32'h300, 32'h1, 32'h0, CHK_NONE, 32'h0, TGT_ALIGN);
      add_entry(OP_LD, SZ_H, 1'b1, 32'h300, 32'h3, 32'h0, CHK_NONE, 32'h0, TGT_ALIGN);
      add_entry(OP_LD, SZ_W, 1'b0, 32'h300, 32'h0, 32'h0, CHK_DATA, 32'hC3A59681, TGT_NONE);
      // TLB miss on a load and a store beyond the RAM
      add_entry(OP_LD, SZ_W, 1'b0, 32'h400, 32'h0, 32'h0, CHK_NONE, 32'h0, TGT_DTM);
      add_entry(OP_ST, SZ_W, 1'b0, 32'h7F0, 32'h10, 32'h0BADF00D, CHK_NONE, 32'h0, TGT_DTM);
      // Page fault on stores into the read-only region
      add_entry(OP_LD, SZ_W, 1'b0, 32'h20, 32'h0, 32'h0, CHK_SAVE, 32'h0, TGT_NONE);
      add_entry(OP_ST, SZ_W, 1'b0, 32'h20, 32'h0, 32'h55AA55AA, CHK_NONE, 32'h0, TGT_DPF);
      add_entry(OP_ST, SZ_B, 1'b0, 32'h3F, 32'h0, 32'h00000077, CHK_NONE, 32'h0, TGT_DPF);
      add_entry(OP_LD, SZ_W, 1'b0, 32'h10, 32'h10, 32'h0, CHK_SAME, 32'h0, TGT_NONE);
      // No memory access
      add_entry(OP_NONE, SZ_W, 1'b0, 32'h300, 32'h0, 32'h0, CHK_NONE, 32'h0, TGT_NONE);
      // Top byte of the RAM
      add_entry(OP_ST, SZ_B, 1'b0, 32'h3FF, 32'h0, 32'h0000005A, CHK_NONE, 32'h0, TGT_NONE);
      add_entry(OP_LD, SZ_B, 1'b1, 32'h3FF, 32'h0, 32'h0, CHK_DATA, 32'h0000005A, TGT_NONE);
   endtask

   // Called just after a falling edge in the cycle where in_ready is high
   task automatic check_result(input entry_t e, input int waited);
      nano_mu_pkg::addr_t lsa_exp;
      logic               exc_exp;
      lsa_exp = e.op1 + e.op2;
      exc_exp = (e.tgt != TGT_NONE);
      assert (exp_taken == exc_exp) else begin
         $display("Fail exp_taken: got %h expected %h", exp_taken, exc_exp);
         abort_run();
      end
      if (e.op == OP_NONE) begin
         assert (waited == 0) else begin
            $display("Request without a memory access did not complete at once");
            abort_run();
         end
      end else begin
         assert (lsa == lsa_exp) else begin
            $display("Fail lsa: got %h expected %h", lsa, lsa_exp);
            abort_run();
         end
      end
      if (exc_exp) begin
         assert (exp_tgt == e.tgt) else begin
            $display("Fail exp_tgt: got %h expected %h", exp_tgt, e.tgt);
            abort_run();
         end
         // Misalignment comes at once and MMU faults one cycle after the command
         assert (waited == ((e.tgt == TGT_ALIGN) ? 0 : 1)) else begin
            $display("Exception came %0d cycles after the request, wrong timing", waited);
            abort_run();
         end
      end else if (e.op != OP_NONE) begin
         assert (wb_valid) else begin
            $display("Access completed without a writeback handshake");
            abort_run();
         end
      end
      if (!exc_exp) begin
         case (e.chk)
            CHK_DATA: assert (load_data === e.data) else begin
               $display("Fail load_data: got %h expected %h", load_data, e.data);
               abort_run();
            end
            CHK_SAVE: saved_word = load_data;
            CHK_SAME: assert (load_data === saved_word) else begin
               $display("Fail load_data: got %h expected %h", load_data, saved_word);
               abort_run();
            end
            default: ;
         endcase
      end
   endtask

   // Starts and ends on a falling edge
   task automatic run_entry(input entry_t e);
      int   stalls;
      int   waited;
      logic done;
      stalls     = $urandom % 4;
      waited     = 0;
      done       = 1'b0;
      in_valid   = 1'b1;
      load       = (e.op == OP_LD);
      store      = (e.op == OP_ST);
      sign_ext   = e.sign;
      load_size  = e.size;
      store_size = e.size;
      operand_1  = e.op1;
      operand_2  = e.op2;
      operand_3  = e.op3;
      while (!done) begin
         // Back-pressure only while a response waits
         if (wb_valid && stalls > 0) begin
            wb_ready = 1'b0;
            stalls--;
         end else begin
            wb_ready = 1'b1;
         end
         #2;
         if (in_ready) begin
            check_result(e, waited);
            done = 1'b1;
         end
         @(negedge clk);
         waited++;
      end
      in_valid = 1'b0;
   endtask

   initial begin
      clk        = 1'b0;
      rst_n      = 1'b0;
      in_valid   = 1'b0;
      load       = 1'b0;
      store      = 1'b0;
      sign_ext   = 1'b0;
      load_size  = '0;
      store_size = '0;
      operand_1  = '0;
      operand_2  = '0;
      operand_3  = '0;
      wb_ready   = 1'b1;
      saved_word = '0;
      void'($urandom(32'h7fc1));
      fill_table();
      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      for (int i = 0; i < N_ENTRIES; i++) begin
         run_entry(stim[i]);
      end
      $display("sim passed");
      $finish;
   end

endmodule

// File: nano_lsu_sva.sv
// ==================================================
// Bound into nano_mu and disabled while rst_n is low
// ==================================================
`timescale 1ns/10ps

module nano_lsu_sva (
   input logic               clk,
   input logic               rst_n,
   input logic               in_valid,
   input logic               in_ready,
   input logic               cmd_valid,
   input logic               cmd_ready,
   input logic               tlb_miss,
   input logic               page_fault,
   input logic               wb_valid,
   input logic               wb_ready,
   input nano_mu_pkg::data_t rsp_dout,
   input logic               exp_taken
);

   // Command accepted and its request not yet completed
   logic cmd_open;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cmd_open <= 1'b0;
      end else if (in_valid && in_ready) begin
         cmd_open <= 1'b0;
      end else if (cmd_valid && cmd_ready) begin
         cmd_open <= 1'b1;
      end
   end

   // One outstanding command at most
   a_no_cmd_pending: assert property (@(posedge clk) disable iff (!rst_n)
      cmd_open |-> !cmd_valid)
      else $error("cmd_valid high while a command is outstanding");

   // MMU classes are exclusive
   a_one_fault: assert property (@(posedge clk) disable iff (!rst_n)
      !(tlb_miss && page_fault))
      else $error("tlb_miss and page_fault high together");

   // Response held under back-pressure
   a_rsp_stable: assert property (@(posedge clk) disable iff (!rst_n)
      (wb_valid && !wb_ready) |=> (wb_valid && $stable(rsp_dout)))
      else $error("response dropped or changed while wb_ready low");

   // An exception never comes with writeback data
   a_exc_no_wb: assert property (@(posedge clk) disable iff (!rst_n)
      !(exp_taken && wb_valid))
      else $error("exp_taken and wb_valid high together");

endmodule

bind nano_mu nano_lsu_sva u_sva (
   .clk        (clk),
   .rst_n      (rst_n),
   .in_valid   (in_valid),
   .in_ready   (in_ready),
   .cmd_valid  (cmd_valid),
   .cmd_ready  (cmd_ready),
   .tlb_miss   (tlb_miss),
   .page_fault (page_fault),
   .wb_valid   (wb_valid),
   .wb_ready   (wb_ready),
   .rsp_dout   (rsp_dout),
   .exp_taken  (exp_taken)
);

// File: nano_lsu_top.sv
// ================================================
// Memory unit, data MMU checker and data RAM
// ================================================
`timescale 1ns/10ps

module nano_lsu_top (
   input  logic                  clk,
   input  logic                  rst_n,
   // Execute request
   input  logic                  in_valid,
   output logic                  in_ready,
   input  logic                  load,
   input  logic                  store,
   input  logic                  sign_ext,
   input  nano_mu_pkg::size_t    load_size,
   input  nano_mu_pkg::size_t    store_size,
   input  nano_mu_pkg::data_t    operand_1,
   input  nano_mu_pkg::data_t    operand_2,
   input  nano_mu_pkg::data_t    operand_3,
   // Writeback
   input  logic                  wb_ready,
   output logic                  wb_valid,
   output nano_mu_pkg::data_t    load_data,
   output logic                  exp_taken,
   output nano_mu_pkg::exp_tgt_t exp_tgt,
   output nano_mu_pkg::addr_t    lsa
);

   // Command, memory unit to MMU checker
   logic                   mu_cmd_valid;
   logic                   mu_cmd_ready;
   nano_mu_pkg::addr_t     cmd_addr;
   nano_mu_pkg::byte_msk_t cmd_we_msk;
   nano_mu_pkg::data_t     cmd_din;
   // Command, MMU checker to RAM
   logic                   ram_cmd_valid;
   logic                   ram_cmd_ready;
   // Response and faults
   logic                   rsp_valid;
   logic                   rsp_ready;
   nano_mu_pkg::data_t     rsp_dout;
   logic                   tlb_miss;
   logic                   page_fault;

   nano_mu u_mu (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_valid   (in_valid),
      .in_ready   (in_ready),
      .load       (load),
      .store      (store),
      .sign_ext   (sign_ext),
      .load_size  (load_size),
      .store_size (store_size),
      .operand_1  (operand_1),
      .operand_2  (operand_2),
      .operand_3  (operand_3),
      .cmd_valid  (mu_cmd_valid),
      .cmd_ready  (mu_cmd_ready),
      .cmd_addr   (cmd_addr),
      .cmd_we_msk (cmd_we_msk),
      .cmd_din    (cmd_din),
      .rsp_valid  (rsp_valid),
      .rsp_ready  (rsp_ready),
      .rsp_dout   (rsp_dout),
      .tlb_miss   (tlb_miss),
      .page_fault (page_fault),
      .wb_ready   (wb_ready),
      .wb_valid   (wb_valid),
      .load_data  (load_data),
      .exp_taken  (exp_taken),
      .exp_tgt    (exp_tgt),
      .lsa        (lsa)
   );

   nano_dmmu u_dmmu (
      .clk           (clk),
      .rst_n         (rst_n),
      .mu_cmd_valid  (mu_cmd_valid),
      .mu_cmd_ready  (mu_cmd_ready),
      .cmd_addr      (cmd_addr),
      .store         (store),
      .ram_cmd_valid (ram_cmd_valid),
      .ram_cmd_ready (ram_cmd_ready),
      .tlb_miss      (tlb_miss),
      .page_fault    (page_fault)
   );

   nano_dram u_dram (
      .clk        (clk),
      .rst_n      (rst_n),
      .cmd_valid  (ram_cmd_valid),
      .cmd_ready  (ram_cmd_ready),
      .cmd_addr   (cmd_addr),
      .cmd_we_msk (cmd_we_msk),
      .cmd_din    (cmd_din),
      .rsp_valid  (rsp_valid),
      .rsp_ready  (rsp_ready),
      .rsp_dout   (rsp_dout)
   );

endmodule

// File: nano_dram.sv
// ================================================
// Contents undefined until written
// One response in flight, upper address bits ignored
// ================================================
`timescale 1ns/10ps
`include "nano_mu_config.svh"

module nano_dram (
   input  logic                   clk,
   input  logic                   rst_n,
   // Command
   input  logic                   cmd_valid,
   output logic                   cmd_ready,
   input  nano_mu_pkg::addr_t     cmd_addr,
   input  nano_mu_pkg::byte_msk_t cmd_we_msk,
   input  nano_mu_pkg::data_t     cmd_din,
   // Response
   output logic                   rsp_valid,
   input  logic                   rsp_ready,
   output nano_mu_pkg::data_t     rsp_dout
);

   localparam int WORDS = `NANO_DRAM_BYTES / 4;
   localparam int IDX_W = $clog2(WORDS);
   localparam int LANES = `NANO_DW / 8;

   nano_mu_pkg::data_t mem [WORDS];
   logic [IDX_W-1:0]   idx;
   logic               hds_cmd;
   logic               hds_rsp;

   // Word index from the byte address
   assign idx = cmd_addr[IDX_W+1:2];

   // No new command while a response waits
   assign cmd_ready = ~rsp_valid;

   assign hds_cmd = cmd_valid & cmd_ready;
   assign hds_rsp = rsp_valid & rsp_ready;

   // Masked lane writes
   always_ff @(posedge clk) begin
      if (hds_cmd) begin
         for (int i = 0; i < LANES; i++) begin
            if (cmd_we_msk[i]) begin
               mem[idx][8*i +: 8] <= cmd_din[8*i +: 8];
            end
         end
      end
   end

   // Read data captured on the command, old value on a store
   // Held stable until the response handshake
   always_ff @(posedge clk) begin
      if (hds_cmd) begin
         rsp_dout <= mem[idx];
      end
   end

   // Response valid flag
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rsp_valid <= 1'b0;
      end else if (hds_cmd) begin
         rsp_valid <= 1'b1;
      end else if (hds_rsp) begin
         rsp_valid <= 1'b0;
      end
   end

endmodule

// File: nano_dmmu.sv
// ================================================
// Flat map without page tables
// Faults pulse for one cycle
// ================================================
`timescale 1ns/10ps
`include "nano_mu_config.svh"

module nano_dmmu (
   input  logic               clk,
   input  logic               rst_n,
   // From the memory unit
   input  logic               mu_cmd_valid,
   output logic               mu_cmd_ready,
   input  nano_mu_pkg::addr_t cmd_addr,
   input  logic               store,
   // To the data RAM
   output logic               ram_cmd_valid,
   input  logic               ram_cmd_ready,
   // Fault flags one cycle after the command
   output logic               tlb_miss,
   output logic               page_fault
);

   logic miss_w;
   logic pf_w;
   logic fault_w;

   // Beyond the RAM is unmapped
   assign miss_w = cmd_addr >= nano_mu_pkg::addr_t'(`NANO_DRAM_BYTES);

   // Stores into the read-only low region fault
   assign pf_w = store & (cmd_addr < nano_mu_pkg::addr_t'(`NANO_RO_BYTES));

   assign fault_w = miss_w | pf_w;

   // Bad commands never reach the RAM
   assign ram_cmd_valid = mu_cmd_valid & ~fault_w;

   // Faulting commands are swallowed here at once
   assign mu_cmd_ready = fault_w ? 1'b1 : ram_cmd_ready;

   // Fault reported in the cycle after acceptance
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tlb_miss   <= 1'b0;
         page_fault <= 1'b0;
      end else begin
         tlb_miss   <= mu_cmd_valid & miss_w;
         page_fault <= mu_cmd_valid & pf_w;
      end
   end

endmodule

// File: nano_mu.sv
// ================================================
// One outstanding access, operands held until in_ready
// Fault flags must arrive one cycle after the command
// ================================================
`timescale 1ns/10ps
`include "nano_mu_config.svh"

module nano_mu (
   input  logic                   clk,
   input  logic                   rst_n,
   // Execute request
   input  logic                   in_valid,
   output logic                   in_ready,
   input  logic                   load,
   input  logic                   store,
   input  logic                   sign_ext,
   input  nano_mu_pkg::size_t     load_size,
   input  nano_mu_pkg::size_t     store_size,
   input  nano_mu_pkg::data_t     operand_1,
   input  nano_mu_pkg::data_t     operand_2,
   input  nano_mu_pkg::data_t     operand_3,
   // Data bus command
   output logic                   cmd_valid,
   input  logic                   cmd_ready,
   output nano_mu_pkg::addr_t     cmd_addr,
   output nano_mu_pkg::byte_msk_t cmd_we_msk,
   output nano_mu_pkg::data_t     cmd_din,
   // Data bus response
   input  logic                   rsp_valid,
   output logic                   rsp_ready,
   input  nano_mu_pkg::data_t     rsp_dout,
   // Faults from the data MMU
   input  logic                   tlb_miss,
   input  logic                   page_fault,
   // Writeback side
   input  logic                   wb_ready,
   output logic                   wb_valid,
   output nano_mu_pkg::data_t     load_data,
   output logic                   exp_taken,
   output nano_mu_pkg::exp_tgt_t  exp_tgt,
   output nano_mu_pkg::addr_t     lsa
);

   nano_mu_pkg::mu_state_e   state_r;
   nano_mu_pkg::mu_state_e   state_nxt;
   nano_mu_pkg::size_t       mu_size;
   nano_mu_pkg::byte_msk_t   msk_byte;
   nano_mu_pkg::byte_msk_t   msk_half;
   logic                     mu_op;
   logic                     misalign;
   logic                     dmm_fault;
   logic                     hds_cmd;
   logic                     hds_wb;
   logic [7:0]               dout_byte;
   logic [15:0]              dout_half;
   logic [`NANO_VECT_DW-1:0] exp_vector;

   assign mu_op   = load | store;
   assign hds_cmd = cmd_valid & cmd_ready;
   assign hds_wb  = wb_valid & wb_ready;

   // Effective address
   assign lsa      = operand_1 + operand_2;
   assign cmd_addr = lsa;

   // Alignment check on the size of the active operation
   assign mu_size  = load ? load_size : store_size;
   assign misalign = in_valid & mu_op &
                     (((mu_size == nano_mu_pkg::SIZE_WORD) & (|lsa[1:0])) |
                      ((mu_size == nano_mu_pkg::SIZE_HALF) & lsa[0]));

   // Lane masks, halfword lanes picked by address bit 1
   always_comb begin
      msk_byte = '0;
      msk_byte[lsa[1:0]] = 1'b1;
   end
   assign msk_half = lsa[1] ? 4'b1100 : 4'b0011;

   // Loads write nothing
   always_comb begin
      cmd_we_msk = '0;
      if (store) begin
         case (store_size)
            nano_mu_pkg::SIZE_WORD: cmd_we_msk = 4'b1111;
            nano_mu_pkg::SIZE_HALF: cmd_we_msk = msk_half;
            nano_mu_pkg::SIZE_BYTE: cmd_we_msk = msk_byte;
            default:                cmd_we_msk = '0;
         endcase
      end
   end

   // Store data copied into every lane, mask does the rest
   always_comb begin
      case (store_size)
         nano_mu_pkg::SIZE_HALF: cmd_din = {2{operand_3[15:0]}};
         nano_mu_pkg::SIZE_BYTE: cmd_din = {4{operand_3[7:0]}};
         default:                cmd_din = operand_3;
      endcase
   end

   // Command only from IDLE and only when aligned
   assign cmd_valid = in_valid & mu_op & (state_r == nano_mu_pkg::IDLE) & ~misalign;

   assign dmm_fault = tlb_miss | page_fault;

   // FSM
   always_comb begin
      state_nxt = state_r;
      case (state_r)
         nano_mu_pkg::IDLE:    if (hds_cmd) state_nxt = nano_mu_pkg::PENDING;
         nano_mu_pkg::PENDING: if (hds_wb | dmm_fault) state_nxt = nano_mu_pkg::IDLE;
         default:              state_nxt = nano_mu_pkg::IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_r <= nano_mu_pkg::IDLE;
      end else begin
         state_r <= state_nxt;
      end
   end

   // MMU faults count only for our own pending command
   assign exp_taken = ((state_r == nano_mu_pkg::PENDING) & dmm_fault) | misalign;

   always_comb begin
      if (misalign)
         exp_vector = `NANO_EALIGN_VECTOR;
      else if (tlb_miss)
         exp_vector = `NANO_EDTM_VECTOR;
      else if (page_fault)
         exp_vector = `NANO_EDPF_VECTOR;
      else
         exp_vector = '0;
   end

   // Vector divided by 4, zero extended
   assign exp_tgt = {{(`NANO_AW - `NANO_VECT_DW){1'b0}}, exp_vector[`NANO_VECT_DW-1:2]};

   // Non-memory ops pass straight through
   assign in_ready = ~mu_op | hds_wb | exp_taken;

   // Response goes straight on to writeback
   assign rsp_ready = wb_ready;
   assign wb_valid  = rsp_valid;

   // Addressed byte and halfword of the returned word
   always_comb begin
      case (cmd_addr[1:0])
         2'b00:   dout_byte = rsp_dout[7:0];
         2'b01:   dout_byte = rsp_dout[15:8];
         2'b10:   dout_byte = rsp_dout[23:16];
         default: dout_byte = rsp_dout[31:24];
      endcase
   end
   assign dout_half = cmd_addr[1] ? rsp_dout[31:16] : rsp_dout[15:0];

   // Sign bit copied only when sign_ext is set
   always_comb begin
      case (load_size)
         nano_mu_pkg::SIZE_HALF: load_data = {{16{sign_ext & dout_half[15]}}, dout_half};
         nano_mu_pkg::SIZE_BYTE: load_data = {{24{sign_ext & dout_byte[7]}}, dout_byte};
         default:                load_data = rsp_dout;
      endcase
   end

endmodule

// File: nano_mu_pkg.sv
// ================================================
// Shared vector types of the load/store unit
// ================================================
`include "nano_mu_config.svh"

package nano_mu_pkg;

   // Byte address on the data bus
   typedef logic [`NANO_AW-1:0] addr_t;

   // One data word
   typedef logic [`NANO_DW-1:0] data_t;

   // One write enable per byte lane
   typedef logic [`NANO_DW/8-1:0] byte_msk_t;

   // Access size code, 1 byte, 2 halfword, 3 word
   typedef logic [2:0] size_t;

   // Exception target, vector address divided by 4
   typedef logic [`NANO_AW-3:0] exp_tgt_t;

   // Size codes as driven by execute
   localparam size_t SIZE_BYTE = 3'd1;
   localparam size_t SIZE_HALF = 3'd2;
   localparam size_t SIZE_WORD = 3'd3;

   // Memory unit states
   typedef enum logic {
      IDLE,
      PENDING
   } mu_state_e;

endpackage

// File: nano_mu_config.svh
// ================================================
// Widths and vectors assume a 32-bit data path
// Region sizes must be powers of two and RO < RAM
// ================================================
`ifndef NANO_MU_CONFIG_SVH
`define NANO_MU_CONFIG_SVH

// Address and data width
`define NANO_AW 32
`define NANO_DW 32

// Width of one exception vector
`define NANO_VECT_DW 8

// Data TLB miss
`define NANO_EDTM_VECTOR 8'h1C
// Data page fault
`define NANO_EDPF_VECTOR 8'h20
// Misaligned access
`define NANO_EALIGN_VECTOR 8'h24

// Data RAM size in bytes, any address at or above is a TLB miss
`define NANO_DRAM_BYTES 1024

// Read-only low region in bytes, stores below it fault
`define NANO_RO_BYTES 64

`endif
